// ==== hw/msx_io_params.svh ====
`ifndef MSX_IO_PARAMS_SVH
`define MSX_IO_PARAMS_SVH

// high five bits of the I/O port address, a[7:3]

// PSG at ports A0..A7
`define MSX_PSG_PORT 5'b10100

// PPI at ports A8..AB
`define MSX_PPI_PORT 5'b10101

// size of the PSG register file
`define MSX_PSG_REGS 16

`endif

// ==== hw/msx_io_pkg.sv ====
`default_nettype none

package msx_io_pkg;

   // primary slot number, 0..3
   typedef logic [1:0] slot_t;

   // peer owning the current I/O cycle
   typedef enum logic [1:0] {
      DEV_NONE = 2'd0,
      DEV_PPI  = 2'd1,
      DEV_PSG  = 2'd2
   } dev_sel_e;

   // 8255 mode word, bit 7 set
   typedef struct packed {
      logic       mode_set;
      logic [1:0] grp_a_mode;
      logic       port_a_in;
      logic       port_ch_in;
      logic       grp_b_mode;
      logic       port_b_in;
      logic       port_cl_in;
   } ppi_mode_t;

   // port C bit set/reset word, bit 7 clear
   typedef struct packed {
      logic       mode_set;
      logic [2:0] unused;
      logic [2:0] bit_sel;
      logic       bit_val;
   } ppi_bsr_t;

   typedef union packed {
      ppi_mode_t mode;
      ppi_bsr_t  bsr;
   } ppi_ctrl_u;

endpackage

`default_nettype wire

// ==== hw/msx_io_decode.sv ====
`default_nettype none

`include "msx_io_params.svh"

module msx_io_decode (
   input  wire                  clk21m,
   input  wire                  exwait_n,
   input  wire [7:0]            a_i,
   input  wire                  iorq_n_i,
   input  wire                  mreq_n_i,
   input  wire                  m1_n_i,
   input  wire                  rd_n_i,
   input  wire                  wr_n_i,
   input  wire [7:0]            ppi_d_i,
   input  wire [7:0]            psg_d_i,
   output msx_io_pkg::dev_sel_e grant_o,
   output logic                 wr_stb_o,
   output logic [7:0]           d_o
);
   import msx_io_pkg::*;

   logic io_cycle;
   logic wr_ack;

   // M1 with IORQ is an interrupt acknowledge, not port I/O
   assign io_cycle = ~iorq_n_i & m1_n_i & (~rd_n_i | ~wr_n_i);

   always_comb begin
      grant_o = DEV_NONE;
      if (io_cycle) begin
         if (a_i[7:3] == `MSX_PSG_PORT)
            grant_o = DEV_PSG;
         else if (a_i[7:3] == `MSX_PPI_PORT)
            grant_o = DEV_PPI;
      end
   end

   // strobe lasts until the first edge, then the ack holds it off
   assign wr_stb_o = ~iorq_n_i & m1_n_i & ~wr_n_i & ~wr_ack;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         wr_ack <= 1'b0;
      else if (iorq_n_i && mreq_n_i)
         wr_ack <= 1'b0;
      else if (wr_stb_o)
         wr_ack <= 1'b1;
   end

   // read data mux, idle bus floats high
   always_comb begin
      d_o = 8'hFF;
      if (!rd_n_i) begin
         case (grant_o)
            DEV_PPI: d_o = ppi_d_i;
            DEV_PSG: d_o = psg_d_i;
            default: d_o = 8'hFF;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/msx_ppi.sv ====
`default_nettype none

module msx_ppi (
   input  wire                  clk21m,
   input  wire                  exwait_n,
   input  msx_io_pkg::dev_sel_e grant_i,
   input  wire                  wr_stb_i,
   input  wire [1:0]            a_i,
   input  wire [7:0]            d_i,
   input  wire [7:0]            kbd_cols_i,
   output logic [7:0]           d_o,
   output logic [7:0]           port_a_o,
   output logic                 wr_seen_o,
   output logic [3:0]           kbd_row_o,
   output logic                 cas_motor_o,
   output logic                 keybeep_o
);
   import msx_io_pkg::*;

   logic [7:0] port_c;
   logic       ppi_wr;
   ppi_ctrl_u  ctrl;

   assign ppi_wr = wr_stb_i && (grant_i == DEV_PPI);
   assign ctrl   = d_i;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_o  <= 8'h00;
         port_c    <= 8'h00;
         wr_seen_o <= 1'b0;
      end else if (ppi_wr) begin
         wr_seen_o <= 1'b1;
         case (a_i)
            // port A is the primary slot register
            2'd0: port_a_o <= d_i;
            2'd2: port_c   <= d_i;
            2'd3: begin
               // mode set clears port C
               if (ctrl.mode.mode_set)
                  port_c <= 8'h00;
               else
                  port_c[ctrl.bsr.bit_sel] <= ctrl.bsr.bit_val;
            end
            // port B is input only
            default: ;
         endcase
      end
   end

   always_comb begin
      case (a_i)
         2'd0:    d_o = port_a_o;
         2'd1:    d_o = kbd_cols_i;
         2'd2:    d_o = port_c;
         default: d_o = 8'hFF;
      endcase
   end

   // port C fans out to the keyboard, cassette and beeper
   assign kbd_row_o   = port_c[3:0];
   assign cas_motor_o = port_c[4];
   assign keybeep_o   = port_c[7];

endmodule

`default_nettype wire

// ==== hw/msx_psg_ports.sv ====
`default_nettype none

`include "msx_io_params.svh"

module msx_psg_ports (
   input  wire                  clk21m,
   input  wire                  exwait_n,
   input  msx_io_pkg::dev_sel_e grant_i,
   input  wire                  wr_stb_i,
   input  wire [1:0]            a_i,
   input  wire [7:0]            d_i,
   input  wire [5:0]            joy0_i,
   input  wire [5:0]            joy1_i,
   input  wire                  cas_in_i,
   output logic [7:0]           d_o
);
   import msx_io_pkg::*;

   localparam int AW = $clog2(`MSX_PSG_REGS);

   logic [AW-1:0] psg_addr;
   logic [7:0]    psg_regs [`MSX_PSG_REGS];
   logic          psg_wr;
   logic [5:0]    joy_sel;

   assign psg_wr = wr_stb_i && (grant_i == DEV_PSG);

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         psg_addr <= '0;
         for (int i = 0; i < `MSX_PSG_REGS; i++)
            psg_regs[i] <= 8'h00;
      end else if (psg_wr) begin
         // A0 latches the address, A1 writes data
         if (a_i == 2'd0)
            psg_addr <= d_i[AW-1:0];
         else if (a_i == 2'd1)
            psg_regs[psg_addr] <= d_i;
      end
   end

   // joystick pins are active low, reg 15 bit 6 picks the port
   assign joy_sel = psg_regs[15][6] ? ~joy1_i : ~joy0_i;

   always_comb begin
      d_o = 8'hFF;
      if (a_i == 2'd2) begin
         if (psg_addr == AW'(14))
            d_o = {cas_in_i, 1'b0, joy_sel};
         else
            d_o = psg_regs[psg_addr];
      end
   end

endmodule

`default_nettype wire

// ==== hw/msx_slot_select.sv ====
`default_nettype none

module msx_slot_select (
   input  wire               clk21m,
   input  wire               exwait_n,
   input  wire [1:0]         a_hi_i,
   input  wire [7:0]         port_a_i,
   input  wire               wr_seen_i,
   output msx_io_pkg::slot_t slot_o
);
   import msx_io_pkg::*;

   logic map_valid;

   // stays set until the next reset
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         map_valid <= 1'b0;
      else if (wr_seen_i)
         map_valid <= 1'b1;
   end

   // two bits of port A per 16 KB page
   assign slot_o = map_valid ? slot_t'(port_a_i[{a_hi_i, 1'b0} +: 2]) : slot_t'(0);

endmodule

`default_nettype wire

// ==== hw/msx_wait_gen.sv ====
`default_nettype none

module msx_wait_gen (
   input  wire  clk21m,
   input  wire  exwait_n,
   input  wire  ce_3m58_p_i,
   input  wire  m1_n_i,
   output logic wait_n_o
);

   logic armed;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_n_o <= 1'b1;
         armed    <= 1'b1;
      end else if (ce_3m58_p_i) begin
         // a wait lasts one cpu clock
         if (!wait_n_o) begin
            wait_n_o <= 1'b1;
         end else if (armed && !m1_n_i) begin
            wait_n_o <= 1'b0;
            armed    <= 1'b0;
         end
         // re-arm once M1 has ended
         if (m1_n_i)
            armed <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hw/msx_io_core.sv ====
`default_nettype none

module msx_io_core (
   input  wire               clk21m,
   input  wire               exwait_n,
   input  wire  [15:0]       a_i,
   input  wire  [7:0]        d_i,
   input  wire               iorq_n_i,
   input  wire               mreq_n_i,
   input  wire               rd_n_i,
   input  wire               wr_n_i,
   input  wire               m1_n_i,
   input  wire               ce_3m58_p_i,
   input  wire  [7:0]        kbd_cols_i,
   input  wire  [5:0]        joy0_i,
   input  wire  [5:0]        joy1_i,
   input  wire               cas_in_i,
   output logic [7:0]        d_o,
   output logic              wait_n_o,
   output msx_io_pkg::slot_t slot_o,
   output logic [3:0]        kbd_row_o,
   output logic              cas_motor_o,
   output logic              keybeep_o
);
   import msx_io_pkg::*;

   dev_sel_e   grant;
   logic       wr_stb;
   logic [7:0] ppi_d;
   logic [7:0] psg_d;
   logic [7:0] ppi_port_a;
   logic       ppi_wr_seen;

   // arbiter for the shared cpu data bus
   msx_io_decode msx_io_decode_inst (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .a_i      (a_i[7:0]),
      .iorq_n_i (iorq_n_i),
      .mreq_n_i (mreq_n_i),
      .m1_n_i   (m1_n_i),
      .rd_n_i   (rd_n_i),
      .wr_n_i   (wr_n_i),
      .ppi_d_i  (ppi_d),
      .psg_d_i  (psg_d),
      .grant_o  (grant),
      .wr_stb_o (wr_stb),
      .d_o      (d_o)
   );

   msx_ppi msx_ppi_inst (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .grant_i     (grant),
      .wr_stb_i    (wr_stb),
      .a_i         (a_i[1:0]),
      .d_i         (d_i),
      .kbd_cols_i  (kbd_cols_i),
      .d_o         (ppi_d),
      .port_a_o    (ppi_port_a),
      .wr_seen_o   (ppi_wr_seen),
      .kbd_row_o   (kbd_row_o),
      .cas_motor_o (cas_motor_o),
      .keybeep_o   (keybeep_o)
   );

   msx_psg_ports msx_psg_ports_inst (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .grant_i  (grant),
      .wr_stb_i (wr_stb),
      .a_i      (a_i[1:0]),
      .d_i      (d_i),
      .joy0_i   (joy0_i),
      .joy1_i   (joy1_i),
      .cas_in_i (cas_in_i),
      .d_o      (psg_d)
   );

   // page select from the top two address bits
   msx_slot_select msx_slot_select_inst (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .a_hi_i    (a_i[15:14]),
      .port_a_i  (ppi_port_a),
      .wr_seen_i (ppi_wr_seen),
      .slot_o    (slot_o)
   );

   msx_wait_gen msx_wait_gen_inst (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ce_3m58_p_i (ce_3m58_p_i),
      .m1_n_i      (m1_n_i),
      .wait_n_o    (wait_n_o)
   );

endmodule

`default_nettype wire

// ==== sim/msx_io_clkgen.sv ====
`default_nettype none

module msx_io_clkgen #(
   parameter int HALF_NS = 50
) (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 1ns;

   initial clk_o = 1'b0;

   // 100 ns period
   always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== sim/msx_io_assert.sv ====
`default_nettype none

module msx_io_assert (
   input wire       clk21m,
   input wire       exwait_n,
   input wire       rd_n_i,
   input wire [7:0] d_o,
   input wire       wait_n_o,
   input wire [1:0] slot_o,
   input wire       ppi_wr_seen
);
   timeunit 1ns;
   timeprecision 1ns;

   logic [4:0] wait_len;

   // length of the current wait period, saturating
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         wait_len <= '0;
      else if (wait_n_o)
         wait_len <= '0;
      else if (wait_len != 5'd31)
         wait_len <= wait_len + 5'd1;
   end

   bus_idle_high: assert property (@(posedge clk21m) disable iff (!exwait_n)
      rd_n_i |-> d_o == 8'hFF)
      else $error("d_o not FF while rd_n_i is high");

   wait_short: assert property (@(posedge clk21m) disable iff (!exwait_n)
      wait_len <= 5'd12)
      else $error("wait_n_o held low for more than 12 clocks");

   slot_zero_early: assert property (@(posedge clk21m) disable iff (!exwait_n)
      !ppi_wr_seen |-> slot_o == 2'd0)
      else $error("slot_o not 0 before the first PPI write");

endmodule

bind msx_io_core msx_io_assert msx_io_assert_inst (
   .clk21m      (clk21m),
   .exwait_n    (exwait_n),
   .rd_n_i      (rd_n_i),
   .d_o         (d_o),
   .wait_n_o    (wait_n_o),
   .slot_o      (slot_o),
   .ppi_wr_seen (ppi_wr_seen)
);

`default_nettype wire

// ==== sim/msx_io_tb.sv ====
`default_nettype none

`include "msx_io_params.svh"

module msx_io_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import msx_io_pkg::*;

   localparam int N_IDLE = 12;
   localparam int N_PRE  = 8;
   localparam int N_PSG  = 40;
   localparam int N_JOY  = 16;
   localparam int N_SLOT = 24;
   localparam int N_PPI  = 32;
   localparam int N_M1   = 6;
   // bus cycles per operation, an M1 cycle counts as three
   localparam int BUS_OPS = N_IDLE + N_PRE + 3 * N_PSG + 4 * N_JOY + 5 * N_SLOT
                            + 5 * N_PPI + 3 * N_M1;
   localparam int TIMEOUT_NS = (BUS_OPS * 10 + 16) * 100 + 20000;
   localparam logic [7:0] PSG_BASE = {`MSX_PSG_PORT, 3'b000};
   localparam logic [7:0] PPI_BASE = {`MSX_PPI_PORT, 3'b000};

   logic        clk21m;
   logic        exwait_n;
   logic [15:0] a_i;
   logic [7:0]  d_i;
   logic        iorq_n_i;
   logic        mreq_n_i;
   logic        rd_n_i;
   logic        wr_n_i;
   logic        m1_n_i;
   logic        ce_3m58_p_i;
   logic [7:0]  kbd_cols_i;
   logic [5:0]  joy0_i;
   logic [5:0]  joy1_i;
   logic        cas_in_i;
   logic [7:0]  d_o;
   logic        wait_n_o;
   slot_t       slot_o;
   logic [3:0]  kbd_row_o;
   logic        cas_motor_o;
   logic        keybeep_o;

   // model state
   logic [7:0]  m_port_a;
   logic [7:0]  m_port_c;
   logic [3:0]  m_psg_addr;
   logic [7:0]  m_psg_regs [`MSX_PSG_REGS];
   logic        m_valid;

   integer      seed;
   int          errors;
   int          checks;
   logic [31:0] rv;
   logic [7:0]  rd;
   logic [7:0]  port;
   logic [3:0]  reg_n;
   ppi_ctrl_u   cw;

   msx_io_clkgen clkgen_inst (.clk_o(clk21m));

   msx_io_core msx_io_core_inst (.*);

   task automatic check_value(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   function automatic logic [7:0] psg_read_value();
      logic [5:0] joy;
      joy = m_psg_regs[15][6] ? ~joy1_i : ~joy0_i;
      if (m_psg_addr == 4'd14)
         return {cas_in_i, 1'b0, joy};
      return m_psg_regs[m_psg_addr];
   endfunction

   function automatic logic [1:0] slot_for_addr(input logic [15:0] addr);
      logic [7:0] sh;
      sh = m_port_a >> {addr[15:14], 1'b0};
      return m_valid ? sh[1:0] : 2'd0;
   endfunction

   // held write, the strobe has to fire on one edge only
   task automatic io_write(input logic [7:0] p, input logic [7:0] data, input int hold);
      int pulses;
      pulses = 0;
      @(negedge clk21m);
      a_i = {8'h00, p};
      d_i = data;
      iorq_n_i = 1'b0;
      wr_n_i = 1'b0;
      repeat (hold) begin
         #10;
         if (msx_io_core_inst.wr_stb)
            pulses++;
         @(negedge clk21m);
      end
      iorq_n_i = 1'b1;
      wr_n_i = 1'b1;
      check_value("wr_stb pulses", 8'(pulses), 8'd1);
   endtask

   task automatic io_read(input logic [7:0] p, output logic [7:0] data);
      @(negedge clk21m);
      a_i = {8'h00, p};
      iorq_n_i = 1'b0;
      rd_n_i = 1'b0;
      #20;
      data = d_o;
      @(negedge clk21m);
      iorq_n_i = 1'b1;
      rd_n_i = 1'b1;
   endtask

   task automatic mem_read(input logic [15:0] addr);
      @(negedge clk21m);
      a_i = addr;
      mreq_n_i = 1'b0;
      rd_n_i = 1'b0;
      #20;
      check_value("slot_o", 8'(slot_o), 8'(slot_for_addr(addr)));
      check_value("d_o", d_o, 8'hFF);
      @(negedge clk21m);
      mreq_n_i = 1'b1;
      rd_n_i = 1'b1;
   endtask

   // opcode fetch with M1 low for 18 clocks, then 8 idle clocks
   task automatic m1_cycle(input logic [15:0] addr);
      int falls;
      int rises;
      logic prev_w;
      logic w;
      logic seen_ce;
      falls = 0;
      rises = 0;
      prev_w = 1'b1;
      seen_ce = 1'b0;
      @(negedge clk21m);
      a_i = addr;
      m1_n_i = 1'b0;
      mreq_n_i = 1'b0;
      rd_n_i = 1'b0;
      for (int i = 0; i < 26; i++) begin
         @(posedge clk21m);
         #10;
         w = wait_n_o;
         if (w != prev_w) begin
            if (!ce_3m58_p_i) begin
               errors++;
               $display("wait_n_o changed on a clock without a ce pulse");
            end
            if (w)
               rises++;
            else
               falls++;
         end
         if (ce_3m58_p_i && !m1_n_i && !seen_ce) begin
            seen_ce = 1'b1;
            check_value("wait_n_o at first ce of M1", 8'(w), 8'd0);
         end
         prev_w = w;
         if (i == 17) begin
            @(negedge clk21m);
            m1_n_i = 1'b1;
            mreq_n_i = 1'b1;
            rd_n_i = 1'b1;
         end
      end
      check_value("wait_n_o falls", 8'(falls), 8'd1);
      check_value("wait_n_o rises", 8'(rises), 8'd1);
   endtask

   initial begin
      int ce_cnt;
      ce_cnt = 0;
      ce_3m58_p_i = 1'b0;
      forever begin
         @(negedge clk21m);
         ce_cnt = (ce_cnt == 5) ? 0 : ce_cnt + 1;
         ce_3m58_p_i = (ce_cnt == 0);
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog timeout, the tests did not finish in time");
      $display("Verification failed");
      $finish;
   end

   initial begin
      seed = 68;
      errors = 0;
      checks = 0;
      exwait_n = 1'b0;
      a_i = 16'h0000;
      d_i = 8'h00;
      iorq_n_i = 1'b1;
      mreq_n_i = 1'b1;
      rd_n_i = 1'b1;
      wr_n_i = 1'b1;
      m1_n_i = 1'b1;
      kbd_cols_i = 8'hFF;
      joy0_i = 6'h3F;
      joy1_i = 6'h3F;
      cas_in_i = 1'b0;
      m_port_a = 8'h00;
      m_port_c = 8'h00;
      m_psg_addr = 4'd0;
      m_valid = 1'b0;
      for (int i = 0; i < `MSX_PSG_REGS; i++)
         m_psg_regs[i] = 8'h00;
      repeat (16) @(negedge clk21m);
      exwait_n = 1'b1;
      check_value("wait_n_o", 8'(wait_n_o), 8'd1);
      check_value("keybeep_o", 8'(keybeep_o), 8'd0);
      check_value("cas_motor_o", 8'(cas_motor_o), 8'd0);
      check_value("kbd_row_o", 8'(kbd_row_o), 8'd0);
      check_value("d_o", d_o, 8'hFF);

      // undecoded ports stay at FF
      for (int i = 0; i < N_IDLE; i++) begin
         rv = $random(seed);
         port = rv[7:0];
         if (port[7:4] == 4'hA)
            port[6] = ~port[6];
         io_read(port, rd);
         check_value("d_o undecoded", rd, 8'hFF);
      end

      // slot 0 until the PPI has been written
      for (int i = 0; i < N_PRE; i++) begin
         rv = $random(seed);
         mem_read(rv[15:0]);
      end

      for (int i = 0; i < N_PSG; i++) begin
         rv = $random(seed);
         joy0_i = rv[5:0];
         joy1_i = rv[11:6];
         cas_in_i = rv[12];
         reg_n = rv[19:16];
         io_write(PSG_BASE, {rv[23:20], reg_n}, 1 + int'(rv[14:13]));
         m_psg_addr = reg_n;
         io_write(PSG_BASE + 8'd1, rv[31:24], 1 + int'(rv[26:25]));
         m_psg_regs[reg_n] = rv[31:24];
         io_read(PSG_BASE + 8'd2, rd);
         check_value("d_o psg", rd, psg_read_value());
      end

      for (int i = 0; i < N_JOY; i++) begin
         rv = $random(seed);
         joy0_i = rv[5:0];
         joy1_i = rv[11:6];
         cas_in_i = rv[12];
         io_write(PSG_BASE, 8'h0F, 1);
         m_psg_addr = 4'd15;
         io_write(PSG_BASE + 8'd1, rv[31:24], 2);
         m_psg_regs[15] = rv[31:24];
         io_write(PSG_BASE, 8'h0E, 1);
         m_psg_addr = 4'd14;
         io_read(PSG_BASE + 8'd2, rd);
         check_value("d_o psg reg 14", rd, psg_read_value());
      end

      for (int i = 0; i < N_SLOT; i++) begin
         rv = $random(seed);
         io_write(PPI_BASE, rv[7:0], 1 + int'(rv[9:8]));
         m_port_a = rv[7:0];
         m_valid = 1'b1;
         repeat (4) begin
            rv = $random(seed);
            mem_read(rv[15:0]);
         end
      end

      for (int i = 0; i < N_PPI; i++) begin
         rv = $random(seed);
         if (rv[1:0] == 2'd0) begin
            io_write(PPI_BASE + 8'd2, rv[15:8], 1 + int'(rv[3:2]));
            m_port_c = rv[15:8];
         end else begin
            if (rv[1:0] == 2'd3) begin
               cw = {1'b1, rv[14:8]};
            end else begin
               cw.bsr.mode_set = 1'b0;
               cw.bsr.unused = rv[6:4];
               cw.bsr.bit_sel = rv[10:8];
               cw.bsr.bit_val = rv[11];
            end
            io_write(PPI_BASE + 8'd3, cw, 1 + int'(rv[3:2]));
            if (cw.mode.mode_set)
               m_port_c = 8'h00;
            else
               m_port_c[cw.bsr.bit_sel] = cw.bsr.bit_val;
         end
         check_value("kbd_row_o", 8'(kbd_row_o), 8'(m_port_c[3:0]));
         check_value("cas_motor_o", 8'(cas_motor_o), 8'(m_port_c[4]));
         check_value("keybeep_o", 8'(keybeep_o), 8'(m_port_c[7]));
         kbd_cols_i = rv[31:24];
         io_read(PPI_BASE + 8'd1, rd);
         check_value("d_o ppi port b", rd, kbd_cols_i);
         io_read(PPI_BASE + 8'd2, rd);
         check_value("d_o ppi port c", rd, m_port_c);
         io_read(PPI_BASE, rd);
         check_value("d_o ppi port a", rd, m_port_a);
      end

      for (int i = 0; i < N_M1; i++) begin
         rv = $random(seed);
         m1_cycle(rv[15:0]);
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/msx_io_pkg.sv
hw/msx_io_decode.sv
hw/msx_ppi.sv
hw/msx_psg_ports.sv
hw/msx_slot_select.sv
hw/msx_wait_gen.sv
hw/msx_io_core.sv
sim/msx_io_clkgen.sv
sim/msx_io_assert.sv
sim/msx_io_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f files.f --top-module msx_io_tb -Mdir "$OBJ" -o msx_io_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"$OBJ/msx_io_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "no result found in $LOG"
   exit 1
fi
exit 0
